// File: rtl/cart_pkg.sv
// Cartridge loader shared definitions
// Download beat and word views, header modes, detected cartridge info,
// cheat record, storage request and the header decode constants
package cart_pkg;

	// ====================
	// Download stream
	// ====================

	// Hi is map type at offset 0, ROM size nibble in [3:0] at the fixed offsets
	// Lo is {ram, rom} size nibbles at offset 0, RAM size nibble in [3:0] otherwise
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} hdr_bytes_t;

	typedef union packed {
		logic [15:0] raw;
		hdr_bytes_t  hdr;
	} dl_word_u;

	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		dl_word_u    data;
	} dl_bus_t;

	// ====================
	// Menu options
	// ====================

	typedef enum logic [2:0] {
		hdr_auto    = 3'd0,
		hdr_none    = 3'd1,
		hdr_lorom   = 3'd2,
		hdr_hirom   = 3'd3,
		hdr_exhirom = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		region_auto = 2'd0,
		region_ntsc = 2'd1,
		region_pal  = 2'd2
	} region_mode_e;

	// ====================
	// Results
	// ====================

	typedef struct packed {
		logic [7:0]  map_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] sector;
	} sd_req_t;

	// Download index reserved for cheat files
	localparam logic [7:0] code_index = 8'hFF;

	localparam logic [3:0] default_rom_size = 4'hC;
	localparam int size_unit = 1024;

	// ROM size byte of each map, RAM size sits two bytes higher
	localparam logic [24:0] lorom_size_offset   = 25'h007FD6;
	localparam logic [24:0] hirom_size_offset   = 25'h00FFD6;
	localparam logic [24:0] exhirom_size_offset = 25'h40FFD6;

endpackage

// File: rtl/rom_header_detect.sv
`timescale 1ns/1ps
// ROM header detection
// Picks map type, ROM and RAM size and region out of the cartridge download,
// then derives the address masks and the PAL flag
module rom_header_detect #(
	parameter int header_bytes = 512
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::dl_bus_t      dl,
	input  logic                   cart_download,
	input  cart_pkg::header_mode_e header_mode,
	input  cart_pkg::region_mode_e region_mode,
	output cart_pkg::cart_info_t   cart
);
	import cart_pkg::*;

	// Copier header in front of the image shifts the internal header
	localparam logic [24:0] hdr_skip = 25'(header_bytes);

	logic [7:0]  map_type;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic        pal;
	logic        hdr_write;
	logic        fixed_map;
	logic [24:0] rom_size_addr;
	logic [24:0] ram_size_addr;

	assign hdr_write = cart_download & dl.wr;

	// ====================
	// Header location
	// ====================

	// Only the forced map modes look inside the internal header
	always_comb begin
		fixed_map = 1'b1;
		case (header_mode)
			hdr_lorom:   rom_size_addr = lorom_size_offset + hdr_skip;
			hdr_hirom:   rom_size_addr = hirom_size_offset + hdr_skip;
			hdr_exhirom: rom_size_addr = exhirom_size_offset + hdr_skip;
			default: begin
				fixed_map     = 1'b0;
				rom_size_addr = '0;
			end
		endcase
		ram_size_addr = rom_size_addr + 25'd2;
	end

	// ====================
	// Field capture
	// ====================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			map_type   <= '0;
			rom_size   <= default_rom_size;
			ram_size   <= '0;
			rom_region <= 1'b0;
		end else if (hdr_write) begin
			// First word carries the copier's map type and size byte
			if (dl.addr == '0) begin
				rom_size <= default_rom_size;
				ram_size <= '0;
				if (header_mode == hdr_auto && dl.data.hdr.lo != '0) begin
					{ram_size, rom_size} <= dl.data.hdr.lo;
				end
				case (header_mode)
					hdr_auto:    map_type <= dl.data.hdr.hi;
					hdr_hirom:   map_type <= 8'd1;
					hdr_exhirom: map_type <= 8'd2;
					default:     map_type <= 8'd0;
				endcase
			end

			// Region code is bit 8 of the second word
			if (dl.addr == 25'd2) begin
				rom_region <= dl.data.hdr.hi[0];
			end

			if (fixed_map && dl.addr == rom_size_addr) begin
				rom_size <= dl.data.hdr.hi[3:0];
			end
			if (fixed_map && dl.addr == ram_size_addr) begin
				ram_size <= dl.data.hdr.lo[3:0];
			end
		end
	end

	// Region only settles once the image is in
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			if (region_mode == region_auto) begin
				pal <= rom_region;
			end else begin
				pal <= (region_mode == region_pal);
			end
		end
	end

	// Mask is size_unit << size, minus one. No RAM means an empty mask
	always_comb begin
		cart.map_type = map_type;
		cart.rom_mask = (24'(size_unit) << rom_size) - 24'd1;
		if (ram_size != '0) begin
			cart.ram_mask = (24'(size_unit) << ram_size) - 24'd1;
		end else begin
			cart.ram_mask = '0;
		end
		cart.pal = pal;
	end

endmodule

// File: rtl/cheat_code_loader.sv
`timescale 1ns/1ps
// Cheat code loader
// Collects eight 16-bit download words into one cheat record and
// pulses cheat_valid once the last word is in
module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::dl_bus_t     dl,
	input  logic                  code_download,
	output cart_pkg::cheat_code_t cheat,
	output logic                  cheat_valid
);

	logic code_write;

	assign code_write = code_download & dl.wr;

	// Low half first, then high half, for each 32-bit field
	always_ff @(posedge clk_sys) begin
		if (code_write) begin
			case (dl.addr[3:0])
				4'd0:  cheat.flags[15:0]    <= dl.data.raw;
				4'd2:  cheat.flags[31:16]   <= dl.data.raw;
				4'd4:  cheat.address[15:0]  <= dl.data.raw;
				4'd6:  cheat.address[31:16] <= dl.data.raw;
				4'd8:  cheat.compare[15:0]  <= dl.data.raw;
				4'd10: cheat.compare[31:16] <= dl.data.raw;
				4'd12: cheat.replace[15:0]  <= dl.data.raw;
				4'd14: cheat.replace[31:16] <= dl.data.raw;
				// Odd offsets carry nothing
				default: ;
			endcase
		end
	end

	// Last word completes the record
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_write && (dl.addr[3:0] == 4'd14);
		end
	end

endmodule

// File: rtl/backup_ram_sequencer.sv
`timescale 1ns/1ps
// Backup RAM sequencer
// Tracks whether battery RAM is backed by a writable image, flags unsaved
// writes and steps sector by sector through loads and saves with storage
module backup_ram_sequencer #(
	parameter int sector_bits = 9
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              cart_download,
	input  logic [23:0]       ram_mask,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_size_nz,
	input  logic              backup_load,
	input  logic              backup_save,
	input  logic              autosave,
	input  logic              osd_open,
	input  logic              bsram_write,
	input  logic              sd_ack,
	output cart_pkg::sd_req_t sd,
	output logic              backup_enabled,
	output logic              backup_busy,
	output logic              backup_loading,
	output logic              backup_pending
);

	typedef enum logic {
		st_idle,
		st_xfer
	} state_e;

	state_e      state;
	logic        download_q;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        save_req;
	logic        load_arm;
	logic        save_arm;
	logic        load_start;
	logic        save_start;
	logic        auto_start;
	logic        start_load;
	logic        ack_rise;
	logic        ack_fall;
	logic [31:0] last_sector;

	// Autosave kicks in when the menu opens with unsaved writes
	assign save_req   = backup_save | (backup_pending & osd_open & autosave);
	assign load_arm   = backup_load & backup_enabled;
	assign save_arm   = save_req & backup_enabled;
	assign load_start = load_arm & ~load_q;
	assign save_start = save_arm & ~save_q;
	assign auto_start = download_q & ~cart_download & img_size_nz & backup_enabled;
	assign start_load = load_start | auto_start;

	assign ack_rise    = sd_ack & ~ack_q;
	assign ack_fall    = ~sd_ack & ack_q;
	assign last_sector = 32'(ram_mask >> sector_bits);
	assign backup_busy = (state == st_xfer);

	// ====================
	// Edge detection
	// ====================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			download_q <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			download_q <= cart_download;
			load_q     <= load_arm;
			save_q     <= save_arm;
			ack_q      <= sd_ack;
		end
	end

	// Save image is mounted by the time the download runs
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			backup_enabled <= 1'b0;
		end else if (cart_download && img_mounted && !img_readonly) begin
			backup_enabled <= |ram_mask;
		end else if (cart_download && !download_q) begin
			backup_enabled <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			backup_pending <= 1'b0;
		end else if (backup_enabled && !osd_open && bsram_write) begin
			backup_pending <= 1'b1;
		end else if (backup_busy) begin
			backup_pending <= 1'b0;
		end
	end

	// ====================
	// Sector transfer
	// ====================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state          <= st_idle;
			backup_loading <= 1'b0;
			sd.rd          <= 1'b0;
			sd.wr          <= 1'b0;
			sd.sector      <= '0;
		end else begin
			// Responder has taken the request
			if (ack_rise) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (start_load || save_start) begin
						state          <= st_xfer;
						backup_loading <= start_load;
						sd.sector      <= '0;
						sd.rd          <= start_load;
						sd.wr          <= ~start_load;
					end
				end
				st_xfer: begin
					// Next sector goes out once ack has dropped
					if (ack_fall) begin
						if (sd.sector >= last_sector) begin
							state          <= st_idle;
							backup_loading <= 1'b0;
						end else begin
							sd.sector <= sd.sector + 32'd1;
							sd.rd     <= backup_loading;
							sd.wr     <= ~backup_loading;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: rtl/cart_loader_top.sv
`timescale 1ns/1ps
// Cartridge loader top level
// Splits the download stream into cartridge and cheat traffic and ties
// header detection, cheat assembly and backup RAM transfer together
module cart_loader_top #(
	parameter int header_bytes = 512,
	parameter int sector_bits  = 9
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::dl_bus_t      dl,
	input  logic                   downloading,
	input  logic [7:0]             dl_index,
	input  cart_pkg::header_mode_e header_mode,
	input  cart_pkg::region_mode_e region_mode,
	input  logic                   backup_load,
	input  logic                   backup_save,
	input  logic                   autosave,
	input  logic                   osd_open,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_size_nz,
	input  logic                   bsram_write,
	input  logic                   sd_ack,
	output cart_pkg::cart_info_t   cart,
	output cart_pkg::cheat_code_t  cheat,
	output logic                   cheat_valid,
	output cart_pkg::sd_req_t      sd,
	output logic                   backup_enabled,
	output logic                   backup_busy,
	output logic                   backup_loading,
	output logic                   backup_pending
);
	import cart_pkg::*;

	logic cart_download;
	logic code_download;

	// Cheat files use their own index, everything else is a ROM image
	assign code_download = downloading & (dl_index == code_index);
	assign cart_download = downloading & (dl_index != code_index);

	rom_header_detect #(
		.header_bytes(header_bytes)
	) i_header (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.cart_download(cart_download),
		.header_mode  (header_mode),
		.region_mode  (region_mode),
		.cart         (cart)
	);

	cheat_code_loader i_cheat (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.code_download(code_download),
		.cheat        (cheat),
		.cheat_valid  (cheat_valid)
	);

	backup_ram_sequencer #(
		.sector_bits(sector_bits)
	) i_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ram_mask      (cart.ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size_nz   (img_size_nz),
		.backup_load   (backup_load),
		.backup_save   (backup_save),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.bsram_write   (bsram_write),
		.sd_ack        (sd_ack),
		.sd            (sd),
		.backup_enabled(backup_enabled),
		.backup_busy   (backup_busy),
		.backup_loading(backup_loading),
		.backup_pending(backup_pending)
	);

endmodule

// File: dv/cart_loader_properties.sv
`timescale 1ns/1ps
// Storage request and cheat pulse properties
// Bound into the backup RAM sequencer and the cheat code loader
module cart_loader_properties (
	input logic              clk_sys,
	input logic              reset,
	input cart_pkg::sd_req_t sd,
	input logic              cheat_valid
);

	int failures = 0;

	// Storage sees either a read or a write, never both
	a_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (!reset)
		!(sd.rd && sd.wr)
	) else begin
		failures++;
		$error("read and write requested together");
	end

	// Sector must not move under a held request
	a_sector_stable: assert property (
		@(posedge clk_sys) disable iff (!reset)
		(sd.rd || sd.wr) |=> (!(sd.rd || sd.wr) || $stable(sd.sector))
	) else begin
		failures++;
		$error("sector changed while a request was held");
	end

	a_cheat_pulse: assert property (
		@(posedge clk_sys) disable iff (!reset)
		cheat_valid |=> !cheat_valid
	) else begin
		failures++;
		$error("cheat_valid held longer than one cycle");
	end

endmodule

bind backup_ram_sequencer cart_loader_properties i_props (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.sd         (sd),
	.cheat_valid(1'b0)
);

bind cheat_code_loader cart_loader_properties i_props (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.sd         ('0),
	.cheat_valid(cheat_valid)
);

// File: dv/tb_cart_loader.sv
`timescale 1ns/1ps
// Cartridge loader testbench
// Random header, cheat and backup RAM traffic against a storage responder,
// checked against expected values worked out in the testbench
module tb_cart_loader;
	import cart_pkg::*;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic        loading;
		logic [31:0] sector;
	} req_log_t;

	localparam logic [24:0] copier_bytes = 25'd512;
	localparam int max_ram_size      = 5;
	localparam int worst_sectors     = 2 ** (max_ram_size + 1);
	localparam int cycles_per_sector = 12;
	localparam int num_transfers     = 7;
	localparam int max_cycles = num_transfers * worst_sectors * cycles_per_sector + 2000;

	logic         clk_sys = 1'b0;
	logic         reset;
	dl_bus_t      dl;
	logic         downloading;
	logic [7:0]   dl_index;
	header_mode_e header_mode;
	region_mode_e region_mode;
	logic         backup_load;
	logic         backup_save;
	logic         autosave;
	logic         osd_open;
	logic         img_mounted;
	logic         img_readonly;
	logic         img_size_nz;
	logic         bsram_write;
	logic         sd_ack;
	cart_info_t   cart;
	cheat_code_t  cheat;
	logic         cheat_valid;
	sd_req_t      sd;
	logic         backup_enabled;
	logic         backup_busy;
	logic         backup_loading;
	logic         backup_pending;

	// Expected cartridge state
	logic [7:0]   exp_map = 8'd0;
	logic [3:0]   exp_rom = 4'hC;
	logic [3:0]   exp_ram = 4'd0;
	logic         exp_region = 1'b0;
	logic         exp_pal = 1'b0;

	logic [24:0]  map_offsets[3] = '{lorom_size_offset, hirom_size_offset, exhirom_size_offset};
	req_log_t     req_log[$];
	int           valid_pulses = 0;
	int           cycle_count = 0;

	cart_loader_top #(
		.header_bytes(512),
		.sector_bits (9)
	) i_dut (
		.*
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_valid) begin
			valid_pulses++;
		end
	end

	always @(negedge clk_sys) begin
		assert (i_dut.i_backup.i_props.failures == 0 && i_dut.i_cheat.i_props.failures == 0)
			else report_error("a bound storage or cheat property failed");
	end

	task automatic report_error(input string msg);
		$display("ERROR [%0t] %s", $time, msg);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	// Size code n spans 1 KB times 2^n
	function automatic logic [23:0] mask_for(input logic [3:0] size);
		logic [31:0] span;
		span = (32'd1 << (size + 5'd10)) - 32'd1;
		return span[23:0];
	endfunction

	// ====================
	// Storage responder
	// ====================

	initial begin
		req_log_t entry;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if ((sd.rd || sd.wr) && !sd_ack) begin
				assert (backup_busy) else report_error("storage request while sequencer idle");
				entry.rd      = sd.rd;
				entry.wr      = sd.wr;
				entry.loading = backup_loading;
				entry.sector  = sd.sector;
				req_log.push_back(entry);
				repeat ($urandom_range(1, 4)) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat ($urandom_range(1, 4)) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		dl.wr       = 1'b1;
		dl.addr     = addr;
		dl.data.raw = data;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	task automatic begin_download(input logic [7:0] index);
		downloading = 1'b1;
		dl_index    = index;
		@(negedge clk_sys);
	endtask

	task automatic finish_download();
		downloading = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_cart();
		logic [23:0] ram_exp;
		ram_exp = (exp_ram == 4'd0) ? 24'd0 : mask_for(exp_ram);
		if (region_mode == region_auto) begin
			exp_pal = exp_region;
		end else begin
			exp_pal = (region_mode == region_pal);
		end
		assert (cart.map_type == exp_map)
			else report_error($sformatf("map type %0h, expected %0h", cart.map_type, exp_map));
		assert (cart.rom_mask == mask_for(exp_rom))
			else report_error($sformatf("ROM mask %0h, expected %0h", cart.rom_mask,
				mask_for(exp_rom)));
		assert (cart.ram_mask == ram_exp)
			else report_error($sformatf("RAM mask %0h, expected %0h", cart.ram_mask, ram_exp));
		assert (cart.pal == exp_pal)
			else report_error($sformatf("PAL flag %0b, expected %0b", cart.pal, exp_pal));
	endtask

	task automatic wait_transfer();
		while (!backup_busy) @(negedge clk_sys);
		while (backup_busy) @(negedge clk_sys);
	endtask

	// Sectors must come out 0, 1, 2 ... in one direction
	task automatic check_transfer(input logic is_load, input int n);
		req_log_t r;
		assert (req_log.size() == n)
			else report_error($sformatf("%0d storage requests, expected %0d", req_log.size(), n));
		for (int i = 0; i < n; i++) begin
			r = req_log[i];
			assert (r.rd == is_load && r.wr == !is_load && r.loading == is_load && r.sector == i)
				else report_error($sformatf("request %0d rd %0b wr %0b loading %0b sector %0d",
					i, r.rd, r.wr, r.loading, r.sector));
		end
		req_log.delete();
	endtask

	initial begin
		logic [15:0] w0;
		logic [15:0] w2;
		logic [15:0] wrom;
		logic [15:0] wram;
		logic [15:0] words[8];
		logic [24:0] base;
		logic [3:0]  ram_pick;
		int          pick;
		int          n;
		int          pulses_before;
		logic        pal_before;
		int          prop_failures;
		cheat_code_t exp_cheat;

		void'($urandom(32'hfa46));
		reset        = 1'b0;
		dl           = '0;
		downloading  = 1'b0;
		dl_index     = 8'd0;
		header_mode  = hdr_auto;
		region_mode  = region_auto;
		backup_load  = 1'b0;
		backup_save  = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		bsram_write  = 1'b0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b1;
		@(negedge clk_sys);
		assert (!cheat_valid && !sd.rd && !sd.wr && !backup_busy && !backup_loading &&
			!backup_pending && !backup_enabled) else report_error("outputs not low after reset");
		check_cart();

		// Auto mode, fields straight from the first two words
		repeat (8) begin
			w0 = 16'($urandom);
			if ($urandom_range(0, 3) == 0) begin
				w0[7:0] = 8'h00;
			end
			w2 = 16'($urandom);
			begin_download(8'($urandom_range(0, 254)));
			write_word(25'd0, w0);
			write_word(25'd2, w2);
			finish_download();
			exp_map    = w0[15:8];
			exp_rom    = (w0[7:0] == 8'h00) ? 4'hC : w0[3:0];
			exp_ram    = (w0[7:0] == 8'h00) ? 4'h0 : w0[7:4];
			exp_region = w2[8];
			check_cart();
		end

		// Forced map modes, sizes from the internal header
		repeat (8) begin
			pick        = $urandom_range(0, 3);
			header_mode = (pick == 0) ? hdr_none : header_mode_e'(pick + 1);
			w0   = 16'($urandom);
			wrom = 16'($urandom);
			wram = 16'($urandom);
			begin_download(8'($urandom_range(0, 254)));
			write_word(25'd0, w0);
			if (pick != 0) begin
				write_word(map_offsets[pick - 1] + copier_bytes, wrom);
				write_word(map_offsets[pick - 1] + copier_bytes + 25'd2, wram);
			end
			for (int m = 0; m < 3; m++) begin
				if (pick == 0 || m != pick - 1) begin
					write_word(map_offsets[m] + copier_bytes, 16'($urandom));
					write_word(map_offsets[m] + copier_bytes + 25'd2, 16'($urandom));
				end
			end
			finish_download();
			exp_map = (pick == 0) ? 8'd0 : 8'(pick - 1);
			exp_rom = (pick == 0) ? 4'hC : wrom[11:8];
			exp_ram = (pick == 0) ? 4'h0 : wram[3:0];
			check_cart();
		end

		// Forced region waits for the end of the download
		header_mode = hdr_auto;
		for (int k = 0; k < 4; k++) begin
			pal_before = exp_pal;
			w0 = 16'($urandom);
			w2 = 16'($urandom);
			begin_download(8'($urandom_range(0, 254)));
			write_word(25'd0, w0);
			write_word(25'd2, w2);
			region_mode = (k % 2 == 1) ? region_pal : region_ntsc;
			@(negedge clk_sys);
			assert (cart.pal == pal_before) else report_error("PAL flag moved during download");
			finish_download();
			exp_map    = w0[15:8];
			exp_rom    = (w0[7:0] == 8'h00) ? 4'hC : w0[3:0];
			exp_ram    = (w0[7:0] == 8'h00) ? 4'h0 : w0[7:4];
			exp_region = w2[8];
			check_cart();
			region_mode = region_auto;
			@(negedge clk_sys);
			check_cart();
		end

		// ====================
		// Cheat records
		// ====================

		begin_download(code_index);
		repeat (2) begin
			base = 25'($urandom) & ~25'hF;
			for (int i = 0; i < 8; i++) begin
				words[i] = 16'($urandom);
			end
			pulses_before = valid_pulses;
			for (int i = 0; i < 8; i++) begin
				write_word(base + 25'(2 * i), words[i]);
				if (i == 3) begin
					write_word(base + 25'd5, 16'($urandom));
				end
			end
			@(negedge clk_sys);
			exp_cheat.flags   = {words[1], words[0]};
			exp_cheat.address = {words[3], words[2]};
			exp_cheat.compare = {words[5], words[4]};
			exp_cheat.replace = {words[7], words[6]};
			assert (cheat == exp_cheat)
				else report_error($sformatf("cheat record %h, expected %h", cheat, exp_cheat));
			assert (valid_pulses == pulses_before + 1)
				else report_error($sformatf("%0d cheat_valid pulses, expected 1",
					valid_pulses - pulses_before));
		end
		finish_download();

		// ====================
		// Backup RAM transfers
		// ====================

		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_size_nz  = 1'b1;
		n = 0;
		repeat (3) begin
			ram_pick = 4'($urandom_range(1, max_ram_size));
			w0 = {8'($urandom), ram_pick, 4'($urandom)};
			n  = int'(mask_for(ram_pick) >> 9) + 1;
			req_log.delete();
			begin_download(8'($urandom_range(0, 254)));
			write_word(25'd0, w0);
			repeat (2) @(negedge clk_sys);
			finish_download();
			wait_transfer();
			check_transfer(1'b1, n);
			exp_map = w0[15:8];
			exp_rom = w0[3:0];
			exp_ram = ram_pick;
			check_cart();
			assert (backup_enabled) else report_error("backup not enabled after download");
			backup_save = 1'b1;
			wait_transfer();
			backup_save = 0;
			check_transfer(1'b0, n);
		end

		// Pending flag and autosave on menu open
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		assert (backup_pending) else report_error("backup_pending not set by RAM write");
		osd_open = 1'b1;
		repeat (10) @(negedge clk_sys);
		assert (!backup_busy && req_log.size() == 0 && backup_pending)
			else report_error("transfer started with autosave off");
		osd_open = 1'b0;
		@(negedge clk_sys);
		autosave = 1'b1;
		@(negedge clk_sys);
		osd_open = 1'b1;
		wait_transfer();
		check_transfer(1'b0, n);
		assert (!backup_pending) else report_error("backup_pending still set after autosave");
		osd_open = 1'b0;
		autosave = 1'b0;
		repeat (4) @(negedge clk_sys);

		prop_failures = i_dut.i_backup.i_props.failures + i_dut.i_cheat.i_props.failures;
		if (prop_failures == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("%0d property failures during the run", prop_failures);
			$display("Test failed");
			$fatal(1, "bound properties failed");
		end
	end

endmodule

// File: src.f
rtl/cart_pkg.sv
rtl/rom_header_detect.sv
rtl/cheat_code_loader.sv
rtl/backup_ram_sequencer.sv
rtl/cart_loader_top.sv
dv/cart_loader_properties.sv
dv/tb_cart_loader.sv
